// ==== common/bus_pkg.sv ====
// Z80 bus decode types
package bus_pkg;

  // port selected by the current address
  typedef enum logic [2:0]
  {
    PK_NONE  = 3'd0,
    PK_FE    = 3'd1, // keyboard and tape
    PK_7FFD  = 3'd2, // 128k paging
    PK_XT    = 3'd3, // extended registers #xxAF
    PK_SDCFG = 3'd4, // z-controller config
    PK_SDDAT = 3'd5  // z-controller data
  } port_kind_e;

endpackage

// ==== common/xt_pkg.sv ====
// extended register types
package xt_pkg;

  // register addressed through #xxAF
  typedef enum logic [2:0]
  {
    XR_STATUS    = 3'd0,
    XR_PAGE      = 3'd1, // any of #10..#13
    XR_FMADDR    = 3'd2,
    XR_SYSCONF   = 3'd3,
    XR_MEMCONF   = 3'd4,
    XR_INTMASK   = 3'd5,
    XR_CACHECONF = 3'd6,
    XR_OTHER     = 3'd7
  } xt_reg_e;

  // memconf[7:6], how #7FFD builds page 3
  typedef enum logic [1:0]
  {
    ML_128     = 2'd0, // plain 128k
    ML_LOCK    = 2'd1, // 128k banks locked
    ML_LOCK_M1 = 2'd2, // opfetch lock, handled as ML_LOCK
    ML_1024    = 2'd3  // pentagon 1024 style
  } mem_lock_e;

endpackage

// ==== common/zports_consts.svh ====
// zports shared constants
`ifndef ZPORTS_CONSTS_SVH
`define ZPORTS_CONSTS_SVH

// bus widths
`define ADDR_W 16
`define DATA_W 8

// low address byte of the decoded ports
`define PORT_FE    8'hFE
`define PORT_FD    8'hFD
`define PORT_XT    8'hAF
`define PORT_SDCFG 8'h77
`define PORT_SDDAT 8'h57

// high address byte of #xxAF
`define XT_STATUS    8'h00
`define XT_RAMPAGE   8'h10 // #10..#13
`define XT_FMADDR    8'h15
`define XT_SYSCONF   8'h20
`define XT_MEMCONF   8'h21
`define XT_INTMASK   8'h2A
`define XT_CACHECONF 8'h2B

// register values after reset
`define RST_PAGE0   8'h00
`define RST_PAGE1   8'h05
`define RST_PAGE2   8'h02
`define RST_PAGE3   8'h00
`define RST_MEMCONF 8'h04 // no rom mapping
`define RST_SYSCONF 8'h00 // 3.5 MHz
`define RST_INTMASK 8'h01 // frame int only

`define NUM_PAGES 4
`define VDAC_VER  3'h0

`endif

// ==== source/bus_decode.sv ====
// I/O strobe and port decoder
`timescale 1ns/1ps
`include "zports_consts.svh"

module bus_decode
  import bus_pkg::*;
  import xt_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [`ADDR_W-1:0] a,
  input  logic               iowr,
  input  logic               iord,
  output port_kind_e         port_kind,
  output xt_reg_e            xt_reg,
  output logic [1:0]         page_idx,
  output logic               wr_stb,
  output logic               rd_stb
);

  logic [7:0] lo_byte;
  logic [7:0] hi_byte;
  logic       iowr_q; // previous sample of iowr
  logic       iord_q;

  assign lo_byte  = a[7:0];
  assign hi_byte  = a[15:8];
  assign page_idx = hi_byte[1:0];

  // one pulse per access, registered
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      iowr_q <= 1'b0;
      iord_q <= 1'b0;
      wr_stb <= 1'b0;
      rd_stb <= 1'b0;
    end
    else
    begin
      iowr_q <= iowr;
      iord_q <= iord;
      wr_stb <= iowr && !iowr_q;
      rd_stb <= iord && !iord_q;
    end
  end

  always_comb
  begin
    case (lo_byte)
      `PORT_FE:    port_kind = PK_FE;
      `PORT_FD:    port_kind = a[15] ? PK_NONE : PK_7FFD; // a15 high is the AY
      `PORT_XT:    port_kind = PK_XT;
      `PORT_SDCFG: port_kind = PK_SDCFG;
      `PORT_SDDAT: port_kind = PK_SDDAT;
      default:     port_kind = PK_NONE;
    endcase
  end

  // high byte of #xxAF
  always_comb
  begin
    case (hi_byte)
      `XT_STATUS:    xt_reg = XR_STATUS;
      `XT_RAMPAGE, `XT_RAMPAGE + 8'd1, `XT_RAMPAGE + 8'd2, `XT_RAMPAGE + 8'd3:
        xt_reg = XR_PAGE;
      `XT_FMADDR:    xt_reg = XR_FMADDR;
      `XT_SYSCONF:   xt_reg = XR_SYSCONF;
      `XT_MEMCONF:   xt_reg = XR_MEMCONF;
      `XT_INTMASK:   xt_reg = XR_INTMASK;
      `XT_CACHECONF: xt_reg = XR_CACHECONF;
      default:       xt_reg = XR_OTHER;
    endcase
  end

endmodule

// ==== source/port_read_mux.sv ====
// port read data mux
`timescale 1ns/1ps
`include "zports_consts.svh"

module port_read_mux
  import bus_pkg::*;
  import xt_pkg::*;
(
  input  port_kind_e                    port_kind,
  input  xt_reg_e                       xt_reg,
  input  logic [1:0]                    page_idx,
  input  logic [`NUM_PAGES*`DATA_W-1:0] xt_page,
  input  logic                          pwr_up,
  input  logic [4:0]                    keys_in,
  input  logic                          tape_read,
  input  logic [`DATA_W-1:0]            sd_dataout,
  input  logic                          iord,
  output logic [`DATA_W-1:0]            dout,
  output logic                          porthit,
  output logic                          dataout
);

  logic [`DATA_W-1:0] xt_dout;

  // only pages 2 and 3 read back
  always_comb
  begin
    case (xt_reg)
      XR_STATUS: xt_dout = {1'b0, pwr_up, 3'b000, `VDAC_VER};
      XR_PAGE:   xt_dout = page_idx[1] ? xt_page[page_idx*`DATA_W +: `DATA_W] : 8'hFF;
      default:   xt_dout = 8'hFF;
    endcase
  end

  always_comb
  begin
    case (port_kind)
      PK_FE:    dout = {1'b1, tape_read, 1'b1, keys_in};
      PK_XT:    dout = xt_dout;
      PK_SDCFG: dout = 8'h00; // card present, not write protected
      PK_SDDAT: dout = sd_dataout;
      default:  dout = 8'hFF;
    endcase
  end

  assign porthit = (port_kind != PK_NONE);
  assign dataout = porthit && iord; // drive the data bus

endmodule

// ==== source/sd_spi_ctrl.sv ====
// Z-controller SD control
`timescale 1ns/1ps
`include "zports_consts.svh"

module sd_spi_ctrl
  import bus_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [`DATA_W-1:0] din,
  input  logic               iowr,
  input  logic               wr_stb,
  input  logic               rd_stb,
  input  port_kind_e         port_kind,
  output logic               sdcs_n,
  output logic               sd2cs_n,
  output logic               sd_start,
  output logic [`DATA_W-1:0] sd_datain
);

  logic cfg_wr;

  assign cfg_wr = wr_stb && (port_kind == PK_SDCFG);

  // both cards deselected after reset
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sdcs_n  <= 1'b1;
      sd2cs_n <= 1'b1;
    end
    else if (cfg_wr)
    begin
      sdcs_n  <= din[1];
      sd2cs_n <= ~din[4];
    end
  end

  // reads shift out FF, one byte per #57 access
  assign sd_start  = (wr_stb || rd_stb) && (port_kind == PK_SDDAT);
  assign sd_datain = iowr ? din : 8'hFF;

endmodule

// ==== source/zports_top.sv ====
// Z80 I/O port decoder top
`timescale 1ns/1ps
`include "zports_consts.svh"

module zports_top
  import bus_pkg::*;
  import xt_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`ADDR_W-1:0]            a,
  input  logic [`DATA_W-1:0]            din,
  input  logic                          iowr,
  input  logic                          iord,
  input  logic [4:0]                    keys_in,
  input  logic                          tape_read,
  input  logic [`DATA_W-1:0]            sd_dataout,
  output logic [`DATA_W-1:0]            dout,
  output logic                          dataout,
  output logic                          porthit,
  output logic [`NUM_PAGES*`DATA_W-1:0] xt_page,
  output logic [`DATA_W-1:0]            memconf,
  output logic [`DATA_W-1:0]            sysconf,
  output logic [3:0]                    cacheconf,
  output logic [`DATA_W-1:0]            intmask,
  output logic [4:0]                    fmaddr,
  output logic                          sdcs_n,
  output logic                          sd2cs_n,
  output logic                          sd_start,
  output logic [`DATA_W-1:0]            sd_datain
);

  port_kind_e         port_kind;
  xt_reg_e            xt_reg;
  logic [1:0]         page_idx;
  logic               wr_stb;
  logic               rd_stb;
  logic               page_wr;
  logic [`DATA_W-1:0] page_val;
  logic               bank_bit;
  logic               pwr_up;

  bus_decode i_bus_decode (
    .clk       (clk),
    .rst       (rst),
    .a         (a),
    .iowr      (iowr),
    .iord      (iord),
    .port_kind (port_kind),
    .xt_reg    (xt_reg),
    .page_idx  (page_idx),
    .wr_stb    (wr_stb),
    .rd_stb    (rd_stb)
  );

  paging_7ffd i_paging_7ffd (
    .clk       (clk),
    .rst       (rst),
    .din       (din),
    .wr_stb    (wr_stb),
    .port_kind (port_kind),
    .memconf   (memconf),
    .page_wr   (page_wr),
    .page_val  (page_val),
    .bank_bit  (bank_bit)
  );

  xt_regfile i_xt_regfile (
    .clk       (clk),
    .rst       (rst),
    .din       (din),
    .wr_stb    (wr_stb),
    .rd_stb    (rd_stb),
    .port_kind (port_kind),
    .xt_reg    (xt_reg),
    .page_idx  (page_idx),
    .page_wr   (page_wr),
    .page_val  (page_val),
    .bank_bit  (bank_bit),
    .xt_page   (xt_page),
    .memconf   (memconf),
    .sysconf   (sysconf),
    .intmask   (intmask),
    .cacheconf (cacheconf),
    .fmaddr    (fmaddr),
    .pwr_up    (pwr_up)
  );

  sd_spi_ctrl i_sd_spi_ctrl (
    .clk       (clk),
    .rst       (rst),
    .din       (din),
    .iowr      (iowr),
    .wr_stb    (wr_stb),
    .rd_stb    (rd_stb),
    .port_kind (port_kind),
    .sdcs_n    (sdcs_n),
    .sd2cs_n   (sd2cs_n),
    .sd_start  (sd_start),
    .sd_datain (sd_datain)
  );

  port_read_mux i_port_read_mux (
    .port_kind  (port_kind),
    .xt_reg     (xt_reg),
    .page_idx   (page_idx),
    .xt_page    (xt_page),
    .pwr_up     (pwr_up),
    .keys_in    (keys_in),
    .tape_read  (tape_read),
    .sd_dataout (sd_dataout),
    .iord       (iord),
    .dout       (dout),
    .porthit    (porthit),
    .dataout    (dataout)
  );

endmodule

// ==== testbench/zports_tb_table.svh ====
// port access table
`ifndef ZPORTS_TB_TABLE_SVH
`define ZPORTS_TB_TABLE_SVH

// name, access, address, data, output checked, expected
task load_table;
  add_row("rst_page", OP_NONE, 16'h0000, 8'h00, CHK_PAGE,
          {`RST_PAGE3, `RST_PAGE2, `RST_PAGE1, `RST_PAGE0});
  add_row("rst_memconf", OP_NONE, 16'h0000, 8'h00, CHK_MEMCONF, {24'h0, `RST_MEMCONF});
  add_row("rst_sysconf", OP_NONE, 16'h0000, 8'h00, CHK_SYSCONF, {24'h0, `RST_SYSCONF});
  add_row("rst_cacheconf", OP_NONE, 16'h0000, 8'h00, CHK_CACHE, 32'h0);
  add_row("rst_intmask", OP_NONE, 16'h0000, 8'h00, CHK_INTMASK, {24'h0, `RST_INTMASK});
  add_row("rst_fmaddr", OP_NONE, 16'h0000, 8'h00, CHK_FMADDR, 32'h0);
  add_row("rst_sd_cs", OP_NONE, 16'h0000, 8'h00, CHK_SDCS, 32'h3);
  add_row("status_first", OP_RD, 16'h00AF, 8'h00, CHK_DOUT, 32'h40); // power-up bit
  add_row("status_second", OP_RD, 16'h00AF, 8'h00, CHK_DOUT, 32'h00);
  add_row("page2_wr", OP_WR, 16'h12AF, 8'h5A, CHK_PAGE, 32'h005A0500);
  add_row("page2_rd", OP_RD, 16'h12AF, 8'h00, CHK_DOUT, 32'h5A);
  add_row("page3_wr", OP_WR, 16'h13AF, 8'hC3, CHK_PAGE, 32'hC35A0500);
  add_row("page3_rd", OP_RD, 16'h13AF, 8'h00, CHK_DOUT, 32'hC3);
  add_row("page1_rd", OP_RD, 16'h11AF, 8'h00, CHK_DOUT, 32'hFF); // not readable
  add_row("intmask_wr", OP_WR, 16'h2AAF, 8'h07, CHK_INTMASK, 32'h07);
  add_row("fmaddr_wr", OP_WR, 16'h15AF, 8'h3F, CHK_FMADDR, 32'h1F);
  add_row("sysconf_wr", OP_WR, 16'h20AF, 8'h04, CHK_CACHE, 32'hF);
  add_row("sysconf_val", OP_NONE, 16'h20AF, 8'h00, CHK_SYSCONF, 32'h04);
  add_row("cacheconf_wr", OP_WR, 16'h2BAF, 8'h05, CHK_CACHE, 32'h5);
  add_row("p128_wr", OP_WR, 16'h7FFD, 8'hD3, CHK_PAGE, 32'h1B5A0500); // 7:6 over 2:0
  add_row("p128_bank", OP_NONE, 16'h7FFD, 8'h00, CHK_MEMCONF, 32'h05);
  add_row("lock_mode", OP_WR, 16'h21AF, 8'h44, CHK_MEMCONF, 32'h44);
  add_row("lock_wr", OP_WR, 16'h7FFD, 8'hD6, CHK_PAGE, 32'h065A0500);
  add_row("lock_bank", OP_NONE, 16'h7FFD, 8'h00, CHK_MEMCONF, 32'h45);
  add_row("lockm1_mode", OP_WR, 16'h21AF, 8'h85, CHK_MEMCONF, 32'h85);
  add_row("lockm1_wr", OP_WR, 16'h7FFD, 8'hC7, CHK_PAGE, 32'h075A0500);
  add_row("lockm1_bank", OP_NONE, 16'h7FFD, 8'h00, CHK_MEMCONF, 32'h84);
  add_row("p1024_mode", OP_WR, 16'h21AF, 8'hC4, CHK_MEMCONF, 32'hC4);
  add_row("p1024_wr", OP_WR, 16'h7FFD, 8'hF5, CHK_PAGE, 32'h3D5A0500); // bit 5 is a page bit
  add_row("p1024_bank", OP_NONE, 16'h7FFD, 8'h00, CHK_MEMCONF, 32'hC5);
  add_row("lock48_mode", OP_WR, 16'h21AF, 8'h04, CHK_MEMCONF, 32'h04);
  add_row("lock48_set", OP_WR, 16'h7FFD, 8'h21, CHK_PAGE, 32'h015A0500);
  add_row("lock48_block", OP_WR, 16'h7FFD, 8'h12, CHK_PAGE, 32'h015A0500);
  add_row("lock48_bank", OP_NONE, 16'h7FFD, 8'h00, CHK_MEMCONF, 32'h04);
  add_row("fe_rd", OP_RD, 16'h00FE, 8'h00, CHK_DOUT, {24'h0, 1'b1, TAPE, 1'b1, KEYS});
  add_row("fe_hit", OP_RD, 16'h00FE, 8'h00, CHK_HIT, 32'h3);
  add_row("fe_wr_hit", OP_WR, 16'h00FE, 8'h00, CHK_HIT, 32'h2); // bus driven on reads only
  add_row("unmapped_rd", OP_RD, 16'h00F7, 8'h00, CHK_DOUT, 32'hFF);
  add_row("unmapped_hit", OP_RD, 16'h00F7, 8'h00, CHK_HIT, 32'h0);
  add_row("sdcfg_wr", OP_WR, 16'h0077, 8'h12, CHK_SDCS, 32'h2); // card 1 off, card 2 on
  add_row("sdcfg_rd", OP_RD, 16'h0077, 8'h00, CHK_DOUT, 32'h00);
  add_row("sddat_datain", OP_WR, 16'h0057, 8'hA5, CHK_DATAIN, 32'hA5);
  add_row("sddat_idle", OP_NONE, 16'h0057, 8'h00, CHK_DATAIN, 32'hFF);
  add_row("sddat_wr_pulse", OP_WR, 16'h0057, 8'h3C, CHK_SDSTART, 32'h1);
  add_row("sddat_rd", OP_RD, 16'h0057, 8'h00, CHK_DOUT, {24'h0, sd_byte});
  add_row("sddat_rd_pulse", OP_RD, 16'h0057, 8'h00, CHK_SDSTART, 32'h1);
endtask

`endif

// ==== testbench/zports_tb.sv ====
// zports testbench
`timescale 1ns/1ps
`include "zports_consts.svh"

module zports_tb;

  localparam int OP_NONE = 0; // check outputs only, no bus access
  localparam int OP_WR   = 1;
  localparam int OP_RD   = 2;

  localparam int CHK_DOUT    = 0;
  localparam int CHK_PAGE    = 1;
  localparam int CHK_MEMCONF = 2;
  localparam int CHK_SYSCONF = 3;
  localparam int CHK_CACHE   = 4;
  localparam int CHK_INTMASK = 5;
  localparam int CHK_FMADDR  = 6;
  localparam int CHK_SDCS    = 7;  // {sdcs_n, sd2cs_n}
  localparam int CHK_HIT     = 8;  // {porthit, dataout}
  localparam int CHK_DATAIN  = 9;
  localparam int CHK_SDSTART = 10; // pulses seen during the access

  localparam int         MAX_ROWS    = 64;
  localparam int         TIMEOUT_CYC = 20;
  localparam logic [4:0] KEYS        = 5'h0A;
  localparam logic       TAPE        = 1'b0;

  logic               clk;
  logic               rst;
  logic [`ADDR_W-1:0] a;
  logic [`DATA_W-1:0] din;
  logic               iowr;
  logic               iord;
  logic [4:0]         keys_in;
  logic               tape_read;
  logic [`DATA_W-1:0] sd_dataout;
  logic [`DATA_W-1:0] dout;
  logic               dataout;
  logic               porthit;
  logic [31:0]        xt_page;
  logic [7:0]         memconf;
  logic [7:0]         sysconf;
  logic [3:0]         cacheconf;
  logic [7:0]         intmask;
  logic [4:0]         fmaddr;
  logic               sdcs_n;
  logic               sd2cs_n;
  logic               sd_start;
  logic [7:0]         sd_datain;

  string       row_name [MAX_ROWS];
  int          row_op   [MAX_ROWS];
  logic [15:0] row_addr [MAX_ROWS];
  logic [7:0]  row_data [MAX_ROWS];
  int          row_chk  [MAX_ROWS];
  logic [31:0] row_exp  [MAX_ROWS];
  int          n_rows;
  int          errors;
  int          timeouts;
  int          sd_pulses;
  integer      seed;
  logic [7:0]  sd_byte;

  zports_top i_zports_top (
    .clk        (clk),
    .rst        (rst),
    .a          (a),
    .din        (din),
    .iowr       (iowr),
    .iord       (iord),
    .keys_in    (keys_in),
    .tape_read  (tape_read),
    .sd_dataout (sd_dataout),
    .dout       (dout),
    .dataout    (dataout),
    .porthit    (porthit),
    .xt_page    (xt_page),
    .memconf    (memconf),
    .sysconf    (sysconf),
    .cacheconf  (cacheconf),
    .intmask    (intmask),
    .fmaddr     (fmaddr),
    .sdcs_n     (sdcs_n),
    .sd2cs_n    (sd2cs_n),
    .sd_start   (sd_start),
    .sd_datain  (sd_datain)
  );

  always #50 clk = ~clk;

  // mid-cycle sample, away from the edges
  always @(negedge clk)
  begin
    if (!rst && sd_start === 1'b1)
      sd_pulses++;
  end

  task add_row(input string name, input int op, input logic [15:0] addr,
               input logic [7:0] data, input int chk, input logic [31:0] exp);
    if (n_rows >= MAX_ROWS)
    begin
      $display("Table overflow: row %s does not fit", name);
      errors++;
    end
    else
    begin
      row_name[n_rows] = name;
      row_op[n_rows]   = op;
      row_addr[n_rows] = addr;
      row_data[n_rows] = data;
      row_chk[n_rows]  = chk;
      row_exp[n_rows]  = exp;
      n_rows++;
    end
  endtask

  `include "zports_tb_table.svh"

  function logic [31:0] pick_output(input int kind);
    case (kind)
      CHK_DOUT:    pick_output = {24'h0, dout};
      CHK_PAGE:    pick_output = xt_page;
      CHK_MEMCONF: pick_output = {24'h0, memconf};
      CHK_SYSCONF: pick_output = {24'h0, sysconf};
      CHK_CACHE:   pick_output = {28'h0, cacheconf};
      CHK_INTMASK: pick_output = {24'h0, intmask};
      CHK_FMADDR:  pick_output = {27'h0, fmaddr};
      CHK_SDCS:    pick_output = {30'h0, sdcs_n, sd2cs_n};
      CHK_HIT:     pick_output = {30'h0, porthit, dataout};
      CHK_DATAIN:  pick_output = {24'h0, sd_datain};
      default:     pick_output = 32'hFFFF_FFFF;
    endcase
  endfunction

  task wait_reset_release;
    int cyc;
    cyc = 0;
    while (!(sdcs_n === 1'b1 && sd2cs_n === 1'b1) && cyc < TIMEOUT_CYC)
    begin
      @(posedge clk);
      cyc++;
    end
    if (!(sdcs_n === 1'b1 && sd2cs_n === 1'b1))
    begin
      $display("Timeout: SD chip selects did not go high after reset");
      timeouts++;
    end
  endtask

  // starts and ends 5 ns after a rising edge
  task run_row(input int i);
    logic [31:0] early;
    logic [31:0] actual;
    int          pulses_at_start;
    early = '0;
    pulses_at_start = sd_pulses;
    if (row_op[i] != OP_NONE)
    begin
      a   = row_addr[i];
      din = row_data[i];
      if (row_op[i] == OP_WR)
        iowr = 1'b1;
      else
        iord = 1'b1;
      @(negedge clk);
      early = pick_output(row_chk[i]); // first cycle of the access
      repeat (3) @(posedge clk);
      #5;
      iowr = 1'b0;
      iord = 1'b0;
      repeat (2) @(posedge clk);
      #5;
    end
    if (row_chk[i] == CHK_SDSTART)
      actual = sd_pulses - pulses_at_start;
    else if (row_op[i] != OP_NONE &&
             (row_chk[i] == CHK_DOUT || row_chk[i] == CHK_HIT || row_chk[i] == CHK_DATAIN))
      actual = early;
    else
      actual = pick_output(row_chk[i]);
    assert (actual === row_exp[i])
    else
    begin
      $display("Mismatch %s: expected %h, actual %h", row_name[i], row_exp[i], actual);
      errors++;
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    a          = '0;
    din        = '0;
    iowr       = 1'b0;
    iord       = 1'b0;
    keys_in    = KEYS;
    tape_read  = TAPE;
    errors     = 0;
    timeouts   = 0;
    sd_pulses  = 0;
    n_rows     = 0;
    seed       = 32'h6151;
    sd_byte    = 8'($random(seed));
    sd_dataout = sd_byte; // card data for #57 reads
    load_table();
    repeat (4) @(posedge clk);
    #5;
    rst = 1'b0;
    wait_reset_release();
    @(posedge clk);
    #5;
    for (int i = 0; i < n_rows; i++)
      run_row(i);
    $display("summary: %0d rows, %0d errors, %0d timeouts", n_rows, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== xt_regs/paging_7ffd.sv ====
// 7FFD paging and lock48
`timescale 1ns/1ps
`include "zports_consts.svh"

module paging_7ffd
  import bus_pkg::*;
  import xt_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [`DATA_W-1:0] din,
  input  logic               wr_stb,
  input  port_kind_e         port_kind,
  input  logic [`DATA_W-1:0] memconf,
  output logic               page_wr,
  output logic [`DATA_W-1:0] page_val,
  output logic               bank_bit
);

  mem_lock_e lock_mode;
  logic      lock48; // 48k lock, cleared only by reset

  assign lock_mode = mem_lock_e'(memconf[7:6]);
  assign page_wr   = wr_stb && (port_kind == PK_7FFD) && !lock48;
  assign bank_bit  = din[4]; // rom bank select

  always_comb
  begin
    case (lock_mode)
      ML_128:             page_val = {3'b000, din[7:6], din[2:0]};
      ML_LOCK, ML_LOCK_M1: page_val = {5'b00000, din[2:0]};
      ML_1024:            page_val = {2'b00, din[5], din[7:6], din[2:0]};
    endcase
  end

  // din[5] is a page bit in 1024 mode, not a lock
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (page_wr && (lock_mode != ML_1024))
      lock48 <= din[5];
  end

endmodule

// ==== xt_regs/xt_regfile.sv ====
// extended configuration registers
`timescale 1ns/1ps
`include "zports_consts.svh"

module xt_regfile
  import bus_pkg::*;
  import xt_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`DATA_W-1:0]            din,
  input  logic                          wr_stb,
  input  logic                          rd_stb,
  input  port_kind_e                    port_kind,
  input  xt_reg_e                       xt_reg,
  input  logic [1:0]                    page_idx,
  input  logic                          page_wr,
  input  logic [`DATA_W-1:0]            page_val,
  input  logic                          bank_bit,
  output logic [`NUM_PAGES*`DATA_W-1:0] xt_page,
  output logic [`DATA_W-1:0]            memconf,
  output logic [`DATA_W-1:0]            sysconf,
  output logic [`DATA_W-1:0]            intmask,
  output logic [3:0]                    cacheconf,
  output logic [4:0]                    fmaddr,
  output logic                          pwr_up
);

  logic [`DATA_W-1:0] page_q [`NUM_PAGES];
  logic               xt_wr;
  logic               status_rd;

  assign xt_wr     = wr_stb && (port_kind == PK_XT);
  assign status_rd = rd_stb && (port_kind == PK_XT) && (xt_reg == XR_STATUS);

  // page 3 in the top byte
  always_comb
  begin
    for (int i = 0; i < `NUM_PAGES; i++)
      xt_page[i*`DATA_W +: `DATA_W] = page_q[i];
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      page_q[0] <= `RST_PAGE0;
      page_q[1] <= `RST_PAGE1;
      page_q[2] <= `RST_PAGE2;
      page_q[3] <= `RST_PAGE3;
      memconf   <= `RST_MEMCONF;
      sysconf   <= `RST_SYSCONF;
      intmask   <= `RST_INTMASK;
      cacheconf <= 4'h0; // cache off
      fmaddr    <= 5'd0;
    end
    else if (page_wr) // #7FFD wins over #xxAF
    begin
      page_q[3]  <= page_val;
      memconf[0] <= bank_bit;
    end
    else if (xt_wr)
    begin
      case (xt_reg)
        XR_PAGE:      page_q[page_idx] <= din;
        XR_FMADDR:    fmaddr <= din[4:0];
        XR_SYSCONF:
        begin
          sysconf   <= din;
          cacheconf <= {4{din[2]}}; // turbo bit enables all cache windows
        end
        XR_MEMCONF:   memconf <= din;
        XR_INTMASK:   intmask <= din;
        XR_CACHECONF: cacheconf <= din[3:0];
        default:      ;
      endcase
    end
  end

  // set at reset, gone after first status read
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pwr_up <= 1'b1;
    else if (status_rd)
      pwr_up <= 1'b0;
  end

endmodule

// ==== zports_top.f ====
+incdir+common
+incdir+testbench
common/bus_pkg.sv
common/xt_pkg.sv
source/bus_decode.sv
xt_regs/xt_regfile.sv
xt_regs/paging_7ffd.sv
source/sd_spi_ctrl.sv
source/port_read_mux.sv
source/zports_top.sv
testbench/zports_tb.sv
